// ==== common/rob_pkg.sv ====
// Shared ROB field widths and enums, compiled ahead of every ROB module that uses them.
package rob_pkg;

   // Program counter width.
   localparam int PC_W = 32;

   // Physical register file address width.
   localparam int PRF_AW = 6;

   // Instruction class carried in the top bits of every entry.
   typedef enum logic [1:0] {
      OP_ALU    = 2'd0,
      OP_BRANCH = 2'd1,
      OP_LOAD   = 2'd2,
      OP_STORE  = 2'd3
   } op_class_e;

   // Packed payload, most significant field first.
   // {class, pc, prd, prd_we, pfree}
   localparam int ENTRY_W = $bits(op_class_e) // class
                          + PC_W              // pc
                          + PRF_AW            // prd
                          + 1                 // prd_we
                          + PRF_AW;           // pfree

   // Four-phase dispatch handshake.
   typedef enum logic {
      DISP_IDLE = 1'b0,
      DISP_ACK  = 1'b1
   } disp_state_e;

endpackage

// ==== rob/rob_ctrl.sv ====
// Dispatch handshake, head bank pointer and bank push/pop strobes, one instance per ROB.
`timescale 1ns/1ps

module rob_ctrl
#(
   parameter int P_COMMIT_WIDTH = 1
)
(
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            disp_req,
   input  logic                            flush,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]  bank_full,
   input  logic [P_COMMIT_WIDTH:0]         pop_size,
   output logic                            disp_ack,
   output logic                            bank_push,
   output logic [(1<<P_COMMIT_WIDTH)-1:0]  bank_pop,
   output logic [P_COMMIT_WIDTH-1:0]       head_ptr
);

   localparam int BANKS = 1 << P_COMMIT_WIDTH;

   rob_pkg::disp_state_e        state_q;
   rob_pkg::disp_state_e        state_d;
   logic                        accept;
   logic                        room;
   logic [P_COMMIT_WIDTH-1:0]   head_q;
   logic [P_COMMIT_WIDTH-1:0]   head_d;

   // Every bank must have a free slot, since a group fills one slot per bank.
   assign room = ~(|bank_full);

   // Group is written on the edge where this is high.
   assign accept = (state_q == rob_pkg::DISP_IDLE) && disp_req && room && !flush;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         rob_pkg::DISP_IDLE:
         begin
            if (accept)
               state_d = rob_pkg::DISP_ACK;
         end
         rob_pkg::DISP_ACK:
         begin
            // Ack is held until the request is seen low.
            if (!disp_req)
               state_d = rob_pkg::DISP_IDLE;
         end
         default:
            state_d = rob_pkg::DISP_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         state_q <= rob_pkg::DISP_IDLE;
      else
         state_q <= state_d;
   end

   // Ack is a pure decode of the registered state.
   assign disp_ack  = (state_q == rob_pkg::DISP_ACK);
   assign bank_push = accept;

   // Head advances modulo BANKS; a full-width pop wraps back onto the same bank.
   assign head_d = flush ? '0 : head_q + pop_size[P_COMMIT_WIDTH-1:0];

   always_ff @(posedge clk)
   begin
      if (reset)
         head_q <= '0;
      else
         head_q <= head_d;
   end

   assign head_ptr = head_q;

   // A bank pops when its distance from the head falls inside the committed run.
   for (genvar i = 0; i < BANKS; i++)
   begin : gen_pop
      logic [P_COMMIT_WIDTH-1:0] offset;

      assign offset      = P_COMMIT_WIDTH'(i) - head_q;
      assign bank_pop[i] = !flush && ({1'b0, offset} < pop_size);
   end

endmodule

// ==== rob/rob_bank.sv ====
// One ROB bank, a circular queue of entries with done and bubble bits, one per dispatch lane.
`timescale 1ns/1ps

module rob_bank
#(
   parameter int P_ROB_DEPTH = 3
)
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         flush,
   input  logic                         push,
   input  logic [rob_pkg::ENTRY_W-1:0]  push_entry,
   input  logic                         push_done,
   input  logic                         pop,
   input  logic                         wb_set,
   input  logic [P_ROB_DEPTH-1:0]       wb_idx,
   output logic                         full,
   output logic [rob_pkg::ENTRY_W-1:0]  head_entry,
   output logic                         head_done,
   output logic                         head_bubble,
   output logic [P_ROB_DEPTH-1:0]       free_idx
);

   localparam int DEPTH = 1 << P_ROB_DEPTH;

   logic [rob_pkg::ENTRY_W-1:0]  payload [DEPTH];
   logic [DEPTH-1:0]             done_q;
   logic [DEPTH-1:0]             bubble_q;
   logic [P_ROB_DEPTH-1:0]       wr_ptr;
   logic [P_ROB_DEPTH-1:0]       rd_ptr;
   logic [P_ROB_DEPTH:0]         count;
   logic                         empty;

   // Pointers and occupancy.
   always_ff @(posedge clk)
   begin
      if (reset || flush)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Slot storage. A bubble enters already done and stays flagged.
   always_ff @(posedge clk)
   begin
      if (wb_set)
         done_q[wb_idx] <= 1'b1;
      // Push comes last so a fresh entry always starts with its own done bit.
      if (push)
      begin
         payload[wr_ptr]  <= push_entry;
         done_q[wr_ptr]   <= push_done;
         bubble_q[wr_ptr] <= push_done;
      end
   end

   assign empty = (count == '0);
   assign full  = (count == (P_ROB_DEPTH+1)'(DEPTH));

   assign head_entry  = payload[rd_ptr];
   // Stale done bits of a free slot must not leak out.
   assign head_done   = done_q[rd_ptr] && !empty;
   assign head_bubble = bubble_q[rd_ptr];
   assign free_idx    = wr_ptr;

endmodule

// ==== rob/rob_commit.sv ====
// ROB commit datapath that rotates bank heads into age order and sizes the retiring run.
`timescale 1ns/1ps

module rob_commit
#(
   parameter int P_COMMIT_WIDTH = 1
)
(
   input  logic [P_COMMIT_WIDTH-1:0]                             head_ptr,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0][rob_pkg::ENTRY_W-1:0]  head_entry,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                        head_done,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                        head_bubble,
   output logic [(1<<P_COMMIT_WIDTH)-1:0]                        cmt_valid,
   output logic [(1<<P_COMMIT_WIDTH)-1:0][rob_pkg::ENTRY_W-1:0]  cmt_entry,
   output logic [P_COMMIT_WIDTH:0]                               pop_size
);

   localparam int BANKS = 1 << P_COMMIT_WIDTH;

   logic [BANKS-1:0] lane_done;
   logic [BANKS-1:0] lane_bubble;
   logic [BANKS-1:0] in_run;

   // Lane 0 is the bank at the head, later lanes follow it around the ring.
   // Banks that wrap past the top already point at the next group.
   for (genvar i = 0; i < BANKS; i++)
   begin : gen_lane
      logic [P_COMMIT_WIDTH-1:0] bank_sel;

      assign bank_sel       = head_ptr + P_COMMIT_WIDTH'(i);
      assign cmt_entry[i]   = head_entry[bank_sel];
      assign lane_done[i]   = head_done[bank_sel];
      assign lane_bubble[i] = head_bubble[bank_sel];
   end

   // Leading run of done lanes.
   // The first lane that is not done stops retirement for all younger lanes.
   always_comb
   begin
      logic run;

      run      = 1'b1;
      pop_size = '0;
      for (int i = 0; i < BANKS; i++)
      begin
         run       = run && lane_done[i];
         in_run[i] = run;
         if (run)
            pop_size = pop_size + 1'b1;
      end
   end

   // Bubbles retire silently.
   assign cmt_valid = in_run & ~lane_bubble;

endmodule

// ==== src/rob_top.sv ====
// Banked reorder buffer top level, tying control, banks and commit together.
`timescale 1ns/1ps

module rob_top
#(
   parameter int P_COMMIT_WIDTH = 1,
   parameter int P_ROB_DEPTH    = 3
)
(
   input  logic                                                        clk,
   input  logic                                                        reset,
   // Dispatch.
   input  logic                                                        disp_req,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                              disp_valid,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0][rob_pkg::ENTRY_W-1:0]        disp_entry,
   output logic                                                        disp_ack,
   // Writeback.
   input  logic                                                        wb_valid,
   input  logic [P_ROB_DEPTH+P_COMMIT_WIDTH-1:0]                       wb_id,
   input  logic                                                        flush,
   // Ids handed to the next dispatch group, one per lane.
   output logic [(1<<P_COMMIT_WIDTH)-1:0][P_ROB_DEPTH+P_COMMIT_WIDTH-1:0] rob_free_id,
   // Commit, lane 0 oldest.
   output logic [(1<<P_COMMIT_WIDTH)-1:0]                              cmt_valid,
   output logic [(1<<P_COMMIT_WIDTH)-1:0][rob_pkg::ENTRY_W-1:0]        cmt_entry
);

   localparam int BANKS = 1 << P_COMMIT_WIDTH;
   localparam int ID_W  = P_ROB_DEPTH + P_COMMIT_WIDTH;

   logic                                       bank_push;
   logic [BANKS-1:0]                           bank_pop;
   logic [BANKS-1:0]                           bank_full;
   logic [P_COMMIT_WIDTH-1:0]                  head_ptr;
   logic [P_COMMIT_WIDTH:0]                    pop_size;
   logic [BANKS-1:0][rob_pkg::ENTRY_W-1:0]     head_entry;
   logic [BANKS-1:0]                           head_done;
   logic [BANKS-1:0]                           head_bubble;
   logic [BANKS-1:0][P_ROB_DEPTH-1:0]          free_idx;
   logic [BANKS-1:0]                           wb_set;
   logic [P_COMMIT_WIDTH-1:0]                  wb_bank;
   logic [P_ROB_DEPTH-1:0]                     wb_idx;

   // Id layout is {index, bank}.
   assign wb_bank = wb_id[P_COMMIT_WIDTH-1:0];
   assign wb_idx  = wb_id[ID_W-1:P_COMMIT_WIDTH];

   rob_ctrl
   #(
      .P_COMMIT_WIDTH (P_COMMIT_WIDTH)
   )
   u_ctrl
   (
      .clk            (clk),
      .reset          (reset),
      .disp_req       (disp_req),
      .flush          (flush),
      .bank_full      (bank_full),
      .pop_size       (pop_size),
      .disp_ack       (disp_ack),
      .bank_push      (bank_push),
      .bank_pop       (bank_pop),
      .head_ptr       (head_ptr)
   );

   // Dispatch lane i always lands in bank i.
   for (genvar i = 0; i < BANKS; i++)
   begin : gen_bank
      localparam logic [P_COMMIT_WIDTH-1:0] BANK_NUM = P_COMMIT_WIDTH'(i);

      assign wb_set[i]      = wb_valid && (wb_bank == BANK_NUM);
      assign rob_free_id[i] = {free_idx[i], BANK_NUM};

      rob_bank
      #(
         .P_ROB_DEPTH (P_ROB_DEPTH)
      )
      u_bank
      (
         .clk         (clk),
         .reset       (reset),
         .flush       (flush),
         .push        (bank_push),
         .push_entry  (disp_entry[i]),
         .push_done   (~disp_valid[i]),
         .pop         (bank_pop[i]),
         .wb_set      (wb_set[i]),
         .wb_idx      (wb_idx),
         .full        (bank_full[i]),
         .head_entry  (head_entry[i]),
         .head_done   (head_done[i]),
         .head_bubble (head_bubble[i]),
         .free_idx    (free_idx[i])
      );
   end

   rob_commit
   #(
      .P_COMMIT_WIDTH (P_COMMIT_WIDTH)
   )
   u_commit
   (
      .head_ptr       (head_ptr),
      .head_entry     (head_entry),
      .head_done      (head_done),
      .head_bubble    (head_bubble),
      .cmt_valid      (cmt_valid),
      .cmt_entry      (cmt_entry),
      .pop_size       (pop_size)
   );

endmodule

// ==== tests/rob_model.svh ====
// Reference model of the ROB as one queue in age order, included into the ROB testbench module.
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

// Entries in dispatch order, lane 0 of each group first.
logic [EW-1:0]    q_entry[$];
bit               q_bubble[$];
bit               q_done[$];
logic [ID_W-1:0]  q_id[$];

// Groups written since reset or flush, modulo the bank depth.
int groups    = 0;
int sent_live = 0;
int dropped   = 0;
// Non-bubble entries seen on cmt_valid.
int committed = 0;

// Every group takes one slot in every bank, so the banks' write pointers move together.
function automatic logic [ID_W-1:0] expected_free_id(input int lane);
   return ID_W'((groups % DEPTH) * BANKS + lane);
endfunction

function automatic void record_group(input logic [BANKS-1:0] valid,
                                     input logic [BANKS-1:0][EW-1:0] entry);
   for (int i = 0; i < BANKS; i++)
   begin
      q_entry.push_back(entry[i]);
      // A bubble is complete from the start.
      q_bubble.push_back(!valid[i]);
      q_done.push_back(!valid[i]);
      q_id.push_back(expected_free_id(i));
      if (valid[i])
         sent_live++;
   end
   groups = (groups + 1) % DEPTH;
endfunction

function automatic void clear_model();
   foreach (q_bubble[i])
      if (!q_bubble[i])
         dropped++;
   q_entry.delete();
   q_bubble.delete();
   q_done.delete();
   q_id.delete();
   groups = 0;
endfunction

// Run of done entries from the oldest one, at most one per bank.
function automatic void predict_commit(output logic [BANKS-1:0] exp_valid, output int n_pop);
   bit run;

   run       = 1'b1;
   exp_valid = '0;
   n_pop     = 0;
   for (int i = 0; i < BANKS; i++)
   begin
      run = run && (i < q_entry.size()) && q_done[i];
      if (run)
      begin
         n_pop++;
         exp_valid[i] = !q_bubble[i];
      end
   end
endfunction

function automatic void retire(input int n);
   for (int i = 0; i < n; i++)
   begin
      void'(q_entry.pop_front());
      void'(q_bubble.pop_front());
      void'(q_done.pop_front());
      void'(q_id.pop_front());
   end
endfunction

function automatic int first_open();
   foreach (q_done[i])
      if (!q_done[i])
         return i;
   return -1;
endfunction

`endif

// ==== tests/tb_rob.sv ====
// Testbench for the banked ROB; random dispatch and writeback are checked against a queue model.
`timescale 1ns/1ps

module tb_rob;

   localparam int BANKS       = 2;
   localparam int DEPTH       = 8;
   localparam int ID_W        = 4;
   localparam int EW          = rob_pkg::ENTRY_W;
   localparam int N_RANDOM    = 200;
   localparam int N_BUBBLE    = 30;
   localparam int N_AFTER_FL  = 12;
   localparam int WAIT_LIMIT  = 200;
   localparam int N_TXN       = 1 + N_RANDOM + N_BUBBLE + DEPTH + 1 + 3 + N_AFTER_FL + 1;
   // 40 cycles of 10 ns per transaction.
   localparam int TIMEOUT_NS  = N_TXN * 40 * 10;

   logic                        clk;
   logic                        reset;
   logic                        disp_req;
   logic [BANKS-1:0]            disp_valid;
   logic [BANKS-1:0][EW-1:0]    disp_entry;
   logic                        disp_ack;
   logic                        wb_valid;
   logic [ID_W-1:0]             wb_id;
   logic                        flush;
   logic [BANKS-1:0][ID_W-1:0]  rob_free_id;
   logic [BANKS-1:0]            cmt_valid;
   logic [BANKS-1:0][EW-1:0]    cmt_entry;

   integer                      seed;
   int                          errors;
   int                          checks;
   int                          test_errors;
   int                          tests_passed;
   int                          tests_failed;
   string                       cur_test;
   int                          wb_mode;   // 0 none, 1 oldest first, 2 random
   bit                          prev_ack;
   bit                          group_pending;
   logic [BANKS-1:0]            pend_valid;
   logic [BANKS-1:0][EW-1:0]    pend_entry;
   logic [ID_W-1:0]             stale_ids[$];

   `include "rob_model.svh"

   rob_top uut (.*);

   always #5 clk = ~clk;

   task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
      checks++;
      assert (exp === act)
      else
      begin
         errors++;
         $display("Fail %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      end
   endtask

   task automatic check_true(input bit cond, input string what);
      checks++;
      assert (cond)
      else
      begin
         errors++;
         $display("Error in %s: %s", cur_test, what);
      end
   endtask

   task automatic check_free_ids();
      for (int i = 0; i < BANKS; i++)
         check_val($sformatf("rob_free_id[%0d]", i), expected_free_id(i), rob_free_id[i]);
   endtask

   // One clock, sampled at the falling edge where outputs are settled.
   task automatic tick();
      bit                req_held;
      logic [BANKS-1:0]  exp_valid;
      int                n_pop;

      req_held = disp_req;
      @(negedge clk);
      if (!prev_ack && disp_ack)
      begin
         check_true(req_held, "disp_ack rose while disp_req was low");
         check_true(group_pending, "disp_ack rose with no group waiting");
         // The group went in at the edge that raised the ack.
         if (group_pending)
            record_group(pend_valid, pend_entry);
         group_pending = 1'b0;
      end
      if (prev_ack && !disp_ack)
         check_true(!req_held, "disp_ack fell while disp_req was still high");
      prev_ack = disp_ack;
      predict_commit(exp_valid, n_pop);
      check_val("cmt_valid", exp_valid, cmt_valid);
      for (int i = 0; i < BANKS; i++)
         if (exp_valid[i])
            check_val($sformatf("cmt_entry[%0d]", i), q_entry[i], cmt_entry[i]);
      committed += $countones(cmt_valid);
      retire(n_pop);
   endtask

   task automatic drive_writeback();
      int cand[$];
      int k;

      k        = -1;
      wb_valid = 1'b0;
      wb_id    = '0;
      if (wb_mode == 1)
         k = first_open();
      else if (wb_mode == 2)
      begin
         foreach (q_done[i])
            if (!q_done[i])
               cand.push_back(i);
         if (cand.size() > 0 && ($random(seed) & 3) != 0)
            k = cand[$unsigned($random(seed)) % cand.size()];
      end
      if (k >= 0)
      begin
         q_done[k] = 1'b1;
         wb_valid  = 1'b1;
         wb_id     = q_id[k];
      end
   endtask

   task automatic cycle();
      tick();
      drive_writeback();
   endtask

   task automatic begin_group(input bit with_bubbles);
      check_free_ids();
      for (int i = 0; i < BANKS; i++)
         pend_entry[i] = {rob_pkg::op_class_e'(2'($random(seed))), 32'($random(seed)),
                          6'($random(seed)), 1'($random(seed)), 6'($random(seed))};
      pend_valid    = with_bubbles ? BANKS'($random(seed)) : '1;
      group_pending = 1'b1;
      disp_valid    = pend_valid;
      disp_entry    = pend_entry;
      disp_req      = 1'b1;
   endtask

   task automatic wait_ack();
      int n;

      n = 0;
      while (group_pending && n < WAIT_LIMIT)
      begin
         cycle();
         n++;
      end
      check_true(!group_pending, "no disp_ack within the wait limit");
      group_pending = 1'b0;
   endtask

   task automatic dispatch(input bit with_bubbles);
      begin_group(with_bubbles);
      wait_ack();
      disp_req = 1'b0;
      cycle();
      check_val("disp_ack after req drop", 0, disp_ack);
   endtask

   task automatic drain();
      int n;

      n = 0;
      while (q_entry.size() > 0 && n < WAIT_LIMIT * 4)
      begin
         cycle();
         n++;
      end
      check_true(q_entry.size() == 0, "entries still pending after the drain limit");
      check_val("committed count", sent_live - dropped, committed);
   endtask

   task automatic start_test(input string name);
      cur_test    = name;
      test_errors = errors;
   endtask

   task automatic end_test();
      if (errors == test_errors)
      begin
         tests_passed++;
         $display("test %s: passed", cur_test);
      end
      else
      begin
         tests_failed++;
         $display("test %s: failed with %0d errors", cur_test, errors - test_errors);
      end
   endtask

   initial
   begin
      seed          = 32'hd244;
      errors        = 0;
      checks        = 0;
      tests_passed  = 0;
      tests_failed  = 0;
      cur_test      = "setup";
      clk           = 1'b0;
      reset         = 1'b1;
      disp_req      = 1'b0;
      disp_valid    = '0;
      disp_entry    = '0;
      wb_valid      = 1'b0;
      wb_id         = '0;
      flush         = 1'b0;
      wb_mode       = 0;
      prev_ack      = 1'b0;
      group_pending = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      start_test("reset");
      check_val("disp_ack", 0, disp_ack);
      check_val("cmt_valid", 0, cmt_valid);
      check_free_ids();
      wb_mode = 1;
      dispatch(1'b0);
      drain();
      end_test();

      start_test("random_writeback");
      wb_mode = 2;
      repeat (N_RANDOM) dispatch(1'b0);
      drain();
      end_test();

      start_test("bubbles");
      repeat (N_BUBBLE) dispatch(1'b1);
      drain();
      end_test();

      // Fill every slot with nothing complete, then ask for one more group.
      start_test("back_pressure");
      wb_mode = 0;
      repeat (DEPTH) dispatch(1'b0);
      begin_group(1'b0);
      repeat (10)
      begin
         cycle();
         check_val("disp_ack while full", 0, disp_ack);
      end
      wb_mode = 1;
      wait_ack();
      disp_req = 1'b0;
      cycle();
      drain();
      end_test();

      start_test("flush");
      wb_mode = 0;
      repeat (3) dispatch(1'b0);
      stale_ids = q_id;
      flush = 1'b1;
      clear_model();
      cycle();
      flush = 1'b0;
      check_free_ids();
      // Completing the flushed ids must not bring any of them back.
      foreach (stale_ids[i])
      begin
         wb_valid = 1'b1;
         wb_id    = stale_ids[i];
         tick();
      end
      wb_valid = 1'b0;
      wb_id    = '0;
      repeat (4) cycle();
      wb_mode = 2;
      repeat (N_AFTER_FL) dispatch(1'b1);
      drain();
      end_test();

      // Request held past the ack must not write a second group.
      start_test("handshake");
      begin_group(1'b0);
      wait_ack();
      repeat (3)
      begin
         cycle();
         check_val("disp_ack while req held", 1, disp_ack);
         check_free_ids();
      end
      disp_req = 1'b0;
      cycle();
      check_val("disp_ack after req drop", 0, disp_ack);
      repeat (3)
      begin
         cycle();
         check_val("disp_ack while idle", 0, disp_ack);
      end
      drain();
      end_test();

      $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
               tests_passed, tests_failed, checks, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      #(TIMEOUT_NS);
      $display("Watchdog expired after %0d ns, the run stopped making progress", TIMEOUT_NS);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+tests
common/rob_pkg.sv
rob/rob_ctrl.sv
rob/rob_bank.sv
rob/rob_commit.sv
src/rob_top.sv
tests/tb_rob.sv

// ==== Makefile ====
# Verilator build, run and lint for the banked ROB.

VERILATOR  ?= verilator
TOP        ?= tb_rob
RTL_TOP    ?= rob_top
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= PASS: all tests
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
